//--- sync_serial_rx.f
+incdir+include
rtl/sync_serial_rx_pkg.sv
rtl/rx_char_if.sv
rtl/rx_line_filter.sv
rtl/rx_bit_framer.sv
rtl/rx_packet_assembler.sv
rtl/sync_serial_rx.sv
dv/tb_clk_gen.sv
dv/tb_sync_serial_rx.sv

//--- Makefile
# Verilator build and run for the serial receiver

VERILATOR ?= verilator
TOP       ?= tb_sync_serial_rx
SEED_ARGS ?= +verilator+seed+53689
FLIST     ?= sync_serial_rx.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# exit status of the simulation is the test result
run: compile
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tb_sync_serial_rx.sv
// serial receiver testbench
`timescale 1ns/100ps
`default_nettype none

`include "sync_serial_rx_cfg.svh"

module tb_sync_serial_rx;

	import sync_serial_rx_pkg::*;

	localparam int MIN_T = `RX_MIN_PERIOD;
	localparam int MAX_T = 48;

	// nonzero period loads a new bit period before the character
	typedef struct packed {
		logic [5:0] period;
		logic       sync;
		logic       ferr;
		logic [7:0] data;
	} line_char_t;

	typedef struct packed {
		logic       is_status;
		rx_status_t status;
		rx_op_t     op;
		logic [7:0] data;
	} result_t;

	logic                    clk_sys;
	logic                    rst_n;
	logic                    rx;
	logic [`RX_PERIOD_W-1:0] tbit_period;
	logic                    data_vld;
	logic [7:0]              data;
	rx_op_t                  data_op;
	logic                    pkt_done;
	rx_status_t              pkt_status;

	line_char_t stim_q[$];
	result_t    exp_q[$];
	int         wd_cycles = 0;

	// reference model state
	asm_state_t mdl_state;
	rx_op_t     mdl_op;
	logic [3:0] mdl_len;
	logic [7:0] mdl_sum;

	tb_clk_gen u_clk_gen (
		.clk_sys (clk_sys),
		.rst_n   (rst_n)
	);

	sync_serial_rx dut (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.rx          (rx),
		.tbit_period (tbit_period),
		.data_vld    (data_vld),
		.data        (data),
		.data_op     (data_op),
		.pkt_done    (pkt_done),
		.pkt_status  (pkt_status)
	);

	// ----------------------------------------
	task automatic stop_fail(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_byte(input logic [7:0] got_data, input rx_op_t got_op);
		result_t head;
		if (exp_q.size() == 0) begin
			stop_fail("payload byte strobe arrived when no result was expected");
		end else begin
			head = exp_q.pop_front();
			if (head.is_status) begin
				stop_fail("payload byte strobe arrived where a packet status was expected");
			end else if (got_data !== head.data) begin
				stop_fail($sformatf("FAIL data: got 0x%02h, expected 0x%02h",
					got_data, head.data));
			end else if (got_op !== head.op) begin
				stop_fail($sformatf("FAIL data_op: got 0x%01h, expected 0x%01h",
					got_op, head.op));
			end
		end
	endtask

	task automatic check_status(input rx_status_t got_status);
		result_t head;
		if (exp_q.size() == 0) begin
			stop_fail("packet done strobe arrived when no result was expected");
		end else begin
			head = exp_q.pop_front();
			if (!head.is_status) begin
				stop_fail("packet done strobe arrived where a payload byte was expected");
			end else if (got_status !== head.status) begin
				stop_fail($sformatf("FAIL pkt_status: got 0x%01h, expected 0x%01h",
					got_status, head.status));
			end
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk_sys) begin
		if (!rst_n) begin
			if (data_vld || pkt_done) begin
				stop_fail("a strobe output is high while reset is asserted");
			end
		end else if (data_vld && pkt_done) begin
			stop_fail("payload byte and packet status strobed in the same cycle");
		end else if (data_vld) begin
			check_byte(data, data_op);
		end else if (pkt_done) begin
			check_status(pkt_status);
		end
	end

	// ----------------------------------------
	// reference model, one call per character
	task automatic push_result(input logic is_st, input rx_status_t st, input rx_op_t op,
		input logic [7:0] d);
		result_t r;
		r.is_status = is_st;
		r.status    = st;
		r.op        = op;
		r.data      = d;
		exp_q.push_back(r);
	endtask

	task automatic model_char(input line_char_t c);
		logic [3:0] op_nib;
		op_nib = c.data[7:4];
		if (mdl_state != HUNT && (c.sync || c.ferr)) begin
			push_result(1'b1, ST_ABORT, OP_NOP, 8'h00);
			mdl_state = HUNT;
		end
		if (c.sync && !c.ferr) begin
			if (op_nib < 4'd1 || op_nib > 4'd4) begin
				push_result(1'b1, ST_BAD_OP, OP_NOP, 8'h00);
			end else begin
				mdl_op    = rx_op_t'(op_nib);
				mdl_len   = c.data[3:0];
				mdl_sum   = c.data;
				mdl_state = (c.data[3:0] == 4'd0) ? CHECK : PAYLOAD;
			end
		end else if (!c.sync && !c.ferr) begin
			if (mdl_state == PAYLOAD) begin
				push_result(1'b0, ST_OK, mdl_op, c.data);
				mdl_sum = mdl_sum ^ c.data;
				mdl_len = mdl_len - 4'd1;
				if (mdl_len == 4'd0) begin
					mdl_state = CHECK;
				end
			end else if (mdl_state == CHECK) begin
				push_result(1'b1, (mdl_sum == c.data) ? ST_OK : ST_BAD_SUM, OP_NOP, 8'h00);
				mdl_state = HUNT;
			end
		end
	endtask

	// ----------------------------------------
	// line driver, short glitches well away from bit edges
	task automatic drive_level(input logic lvl, input int cycles, input logic noisy);
		int i;
		int g_start;
		int g_len;
		g_start = -1;
		g_len   = 0;
		if (noisy && cycles >= 24 && $urandom_range(2, 0) != 0) begin
			g_start = int'($urandom_range(cycles - 4, 14));
			g_len   = int'($urandom_range(`RX_FILT_DIV, 1));
		end
		for (i = 0; i < cycles; i++) begin
			@(posedge clk_sys);
			#1;
			rx = (i >= g_start && i < g_start + g_len) ? ~lvl : lvl;
		end
	endtask

	task automatic send_char(input line_char_t c);
		int         t;
		int         i;
		logic [7:0] bits;
		if (c.period != 6'd0) begin
			drive_level(1'b1, 64, 1'b1);
			tbit_period = `RX_PERIOD_W'(c.period);
		end
		model_char(c);
		t    = int'(tbit_period);
		bits = c.data;
		drive_level(1'b0, t, 1'b1);
		for (i = 0; i < 8; i++) begin
			drive_level(bits[7], t, 1'b1);
			bits = {bits[6:0], 1'b0};
		end
		drive_level(~c.ferr, t, 1'b1);
		drive_level(~c.sync, t, 1'b1);
		drive_level(1'b1, t + int'($urandom_range(t, 8)), 1'b1);
	endtask

	// ----------------------------------------
	// stimulus list
	task automatic add_char(input logic [7:0] d, input logic sync, input logic ferr,
		input logic [5:0] period);
		line_char_t c;
		c.period = period;
		c.sync   = sync;
		c.ferr   = ferr;
		c.data   = d;
		stim_q.push_back(c);
	endtask

	// cut below zero sends the whole packet, else only cut payload bytes
	task automatic add_packet(input logic [3:0] op, input logic [3:0] len, input int cut,
		input logic bad_sum, input logic [5:0] period);
		int         i;
		logic [7:0] sum;
		logic [7:0] pay;
		sum = {op, len};
		add_char(sum, 1'b1, 1'b0, period);
		for (i = 0; i < ((cut < 0) ? int'(len) : cut); i++) begin
			pay = 8'($urandom);
			sum = sum ^ pay;
			add_char(pay, 1'b0, 1'b0, 6'd0);
		end
		if (bad_sum) begin
			sum = sum ^ 8'($urandom_range(255, 1));
		end
		if (cut < 0) begin
			add_char(sum, 1'b0, 1'b0, 6'd0);
		end
	endtask

	function automatic logic [3:0] valid_op();
		return 4'($urandom_range(4, 1));
	endfunction

	function automatic logic [3:0] invalid_op();
		int unsigned v;
		v = $urandom_range(11, 0);
		return (v == 0) ? 4'd0 : 4'(v + 4);
	endfunction

	function automatic logic [5:0] new_period();
		return 6'($urandom_range(MAX_T, MIN_T));
	endfunction

	task automatic build_stimulus();
		int         n;
		int         k;
		logic [3:0] len;
		// idle link, no sync marks
		for (n = 0; n < 4; n++) begin
			add_char(8'($urandom), 1'b0, 1'($urandom_range(1, 0)), 6'd0);
		end
		add_packet(valid_op(), 4'd0, -1, 1'b0, new_period());
		add_packet(valid_op(), 4'd15, -1, 1'b0, new_period());
		for (n = 0; n < 16; n++) begin
			add_packet(4'(n % 4 + 1), 4'($urandom_range(15, 0)), -1, 1'b0, new_period());
		end
		for (n = 0; n < 6; n++) begin
			add_packet(valid_op(), 4'($urandom_range(15, 0)), -1, 1'b1, new_period());
		end
		// bad opcode, trailing plain characters are dropped
		for (n = 0; n < 6; n++) begin
			add_char({invalid_op(), 4'($urandom)}, 1'b1, 1'b0, new_period());
			for (k = 0; k < 3; k++) begin
				add_char(8'($urandom), 1'b0, 1'b0, 6'd0);
			end
			add_packet(valid_op(), 4'($urandom_range(15, 0)), -1, 1'b0, 6'd0);
		end
		// aborted packets, by sync mark, framing error or bad header
		for (n = 0; n < 12; n++) begin
			len = 4'($urandom_range(15, 1));
			add_packet(valid_op(), len, int'($urandom_range(int'(len), 0)), 1'b0, new_period());
			if (n % 3 == 1) begin
				add_char(8'($urandom), 1'($urandom_range(1, 0)), 1'b1, 6'd0);
			end else if (n % 3 == 2) begin
				add_char({invalid_op(), 4'($urandom)}, 1'b1, 1'b0, 6'd0);
			end
			add_packet(valid_op(), 4'($urandom_range(15, 0)), -1, 1'b0, 6'd0);
		end
	endtask

	// ----------------------------------------
	initial begin : main
		int drain;
		void'($urandom(32'hd1b9));
		rx          = 1'b1;
		tbit_period = `RX_PERIOD_W'(MIN_T * 2);
		mdl_state   = HUNT;
		mdl_op      = OP_NOP;
		mdl_len     = 4'd0;
		mdl_sum     = 8'h00;
		build_stimulus();
		wd_cycles = stim_q.size() * 12 * MAX_T * 2 + 4096;
		@(posedge rst_n);
		while (stim_q.size() != 0) begin
			send_char(stim_q.pop_front());
		end
		drain = 0;
		while (exp_q.size() != 0 && drain < 16 * MAX_T) begin
			@(posedge clk_sys);
			drain++;
		end
		// quiet noisy line afterwards, nothing more may be strobed
		drive_level(1'b1, 4 * MAX_T, 1'b1);
		if (exp_q.size() != 0) begin
			stop_fail($sformatf("%0d expected results never arrived", exp_q.size()));
		end else begin
			$display("test passed");
			$finish;
		end
	end

	initial begin : watchdog
		wait (wd_cycles != 0);
		repeat (wd_cycles) @(posedge clk_sys);
		stop_fail($sformatf("run did not finish within %0d cycles", wd_cycles));
	end

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
// testbench clock and reset
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
	output logic clk_sys,
	output logic rst_n
);

	// 4 ns period
	initial begin
		clk_sys = 1'b0;
		forever begin
			#2 clk_sys = ~clk_sys;
		end
	end

	// reset low for 5 cycles, released just after an edge
	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk_sys);
		#1 rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- rtl/sync_serial_rx.sv
// serial link receiver top
`timescale 1ns/100ps
`default_nettype none

`include "sync_serial_rx_cfg.svh"

module sync_serial_rx (
	input  wire                             clk_sys,
	input  wire                             rst_n,
	input  wire                             rx,
	input  wire [`RX_PERIOD_W-1:0]          tbit_period,
	output logic                            data_vld,
	output logic [7:0]                      data,
	output sync_serial_rx_pkg::rx_op_t      data_op,
	output logic                            pkt_done,
	output sync_serial_rx_pkg::rx_status_t  pkt_status
);

	logic line_clean;

	rx_char_if char_bus ();

	// ----------------------------------------
	// line filter, then framer, then assembler
	rx_line_filter u_filter (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.rx         (rx),
		.line_clean (line_clean)
	);

	rx_bit_framer u_framer (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.line_clean  (line_clean),
		.tbit_period (tbit_period),
		.char        (char_bus.framer)
	);

	rx_packet_assembler u_assembler (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.char       (char_bus.assembler),
		.data_vld   (data_vld),
		.data       (data),
		.data_op    (data_op),
		.pkt_done   (pkt_done),
		.pkt_status (pkt_status)
	);

endmodule

`default_nettype wire

//--- rtl/rx_packet_assembler.sv
// sync aligned packet assembler
`timescale 1ns/100ps
`default_nettype none

module rx_packet_assembler (
	input  wire                             clk_sys,
	input  wire                             rst_n,
	rx_char_if.assembler                    char,
	output logic                            data_vld,
	output logic [7:0]                      data,
	output sync_serial_rx_pkg::rx_op_t      data_op,
	output logic                            pkt_done,
	output sync_serial_rx_pkg::rx_status_t  pkt_status
);

	import sync_serial_rx_pkg::*;

	asm_state_t state;
	rx_op_t     hdr_op;
	rx_op_t     op_q;
	logic [3:0] len_q;
	logic [7:0] sum_q;
	logic       op_ok;
	logic       in_pkt;
	logic       hdr_seen;
	logic       abort;
	logic       pay_byte;
	logic       sum_byte;
	logic       bad_op_now;
	logic       bad_op_pend;

	// ----------------------------------------
	// character decode
	assign hdr_op = rx_op_t'(char.char_data[7:4]);
	assign op_ok  = hdr_op inside {OP_WRITE, OP_READ, OP_EVENT, OP_NOP};
	assign in_pkt = (state != HUNT);

	// any clean sync mark is a header, also mid packet
	assign hdr_seen = char.char_vld & char.char_sync & ~char.char_ferr;
	assign abort    = char.char_vld & in_pkt & (char.char_ferr | char.char_sync);
	assign pay_byte = char.char_vld & (state == PAYLOAD) & ~char.char_ferr & ~char.char_sync;
	assign sum_byte = char.char_vld & (state == CHECK) & ~char.char_ferr & ~char.char_sync;

	// bad opcode while hunting reports at once
	assign bad_op_now = hdr_seen & ~op_ok & ~in_pkt;

	// ----------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state       <= HUNT;
			data_vld    <= 1'b0;
			pkt_done    <= 1'b0;
			bad_op_pend <= 1'b0;
		end else begin
			data_vld <= pay_byte;
			pkt_done <= abort | sum_byte | bad_op_now | bad_op_pend;
			// abort strobe goes first, bad opcode one cycle later
			bad_op_pend <= hdr_seen & ~op_ok & in_pkt;
			if (hdr_seen) begin
				if (!op_ok) begin
					state <= HUNT;
				end else if (char.char_data[3:0] == 4'd0) begin
					state <= CHECK;
				end else begin
					state <= PAYLOAD;
				end
			end else if (abort || sum_byte) begin
				state <= HUNT;
			end else if (pay_byte && len_q == 4'd1) begin
				state <= CHECK;
			end
		end
	end

	// ----------------------------------------
	// header latch, running xor and payload out
	always_ff @(posedge clk_sys) begin
		if (hdr_seen) begin
			op_q  <= hdr_op;
			len_q <= char.char_data[3:0];
			sum_q <= char.char_data;
		end else if (pay_byte) begin
			len_q   <= len_q - 4'd1;
			sum_q   <= sum_q ^ char.char_data;
			data    <= char.char_data;
			data_op <= op_q;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (abort) begin
			pkt_status <= ST_ABORT;
		end else if (sum_byte) begin
			pkt_status <= (sum_q == char.char_data) ? ST_OK : ST_BAD_SUM;
		end else if (bad_op_now || bad_op_pend) begin
			pkt_status <= ST_BAD_OP;
		end
	end

endmodule

`default_nettype wire

//--- rtl/rx_bit_framer.sv
// serial bit framer
`timescale 1ns/100ps
`default_nettype none

`include "sync_serial_rx_cfg.svh"

module rx_bit_framer (
	input  wire                    clk_sys,
	input  wire                    rst_n,
	input  wire                    line_clean,
	input  wire [`RX_PERIOD_W-1:0] tbit_period,
	rx_char_if.framer              char
);

	import sync_serial_rx_pkg::*;

	frm_state_t              state;
	frm_state_t              state_nxt;
	logic                    line_q;
	logic                    fall;
	logic                    busy;
	logic                    finish_bit;
	logic                    mid_bit;
	logic [`RX_PERIOD_W-1:0] cnt_cycle;
	logic [`RX_PERIOD_W-1:0] mid_point;
	logic [7:0]              data_int;
	logic                    stop1_low;
	logic                    stop2_low;

	// start edge on the filtered line
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			line_q <= 1'b1;
		end else begin
			line_q <= line_clean;
		end
	end

	assign fall = line_q & ~line_clean;

	// ----------------------------------------
	// main FSM, one bit period per state
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:  state_nxt = fall ? START : IDLE;
			START: state_nxt = finish_bit ? D7 : START;
			D7:    state_nxt = finish_bit ? D6 : D7;
			D6:    state_nxt = finish_bit ? D5 : D6;
			D5:    state_nxt = finish_bit ? D4 : D5;
			D4:    state_nxt = finish_bit ? D3 : D4;
			D3:    state_nxt = finish_bit ? D2 : D3;
			D2:    state_nxt = finish_bit ? D1 : D2;
			D1:    state_nxt = finish_bit ? D0 : D1;
			D0:    state_nxt = finish_bit ? STOP1 : D0;
			STOP1: state_nxt = finish_bit ? STOP2 : STOP1;
			STOP2: state_nxt = finish_bit ? DONE : STOP2;
			DONE:  state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// ----------------------------------------
	// bit timing
	assign busy       = (state != IDLE) && (state != DONE);
	assign finish_bit = (cnt_cycle == tbit_period - 1'b1);
	assign mid_point  = (tbit_period >> 1) - 1'b1;
	assign mid_bit    = (cnt_cycle == mid_point);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cnt_cycle <= '0;
		end else if (!busy || finish_bit) begin
			cnt_cycle <= '0;
		end else begin
			cnt_cycle <= cnt_cycle + 1'b1;
		end
	end

	// mid bit sampling, msb first
	always_ff @(posedge clk_sys) begin
		if (mid_bit) begin
			case (state)
				D7:    data_int[7] <= line_clean;
				D6:    data_int[6] <= line_clean;
				D5:    data_int[5] <= line_clean;
				D4:    data_int[4] <= line_clean;
				D3:    data_int[3] <= line_clean;
				D2:    data_int[2] <= line_clean;
				D1:    data_int[1] <= line_clean;
				D0:    data_int[0] <= line_clean;
				STOP1: stop1_low   <= ~line_clean;
				STOP2: stop2_low   <= ~line_clean;
				default: ;
			endcase
		end
	end

	// ----------------------------------------
	// character out, one strobe per frame
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			char.char_vld <= 1'b0;
		end else begin
			char.char_vld <= (state == DONE);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (state == DONE) begin
			char.char_data <= data_int;
			char.char_sync <= stop2_low;
			char.char_ferr <= stop1_low;
		end
	end

endmodule

`default_nettype wire

//--- rtl/rx_line_filter.sv
// serial line glitch filter
`timescale 1ns/100ps
`default_nettype none

`include "sync_serial_rx_cfg.svh"

module rx_line_filter (
	input  wire  clk_sys,
	input  wire  rst_n,
	input  wire  rx,
	output logic line_clean
);

	localparam int DIV_W = $clog2(`RX_FILT_DIV + 1);

	logic [1:0]               sync_q;
	logic [DIV_W-1:0]         div_cnt;
	logic                     tick;
	logic [`RX_FILT_TAPS-1:0] samples;

	// ----------------------------------------
	// two flop synchroniser, line idles high
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			sync_q <= 2'b11;
		end else begin
			sync_q <= {sync_q[0], rx};
		end
	end

	// sample prescaler
	assign tick = (div_cnt == DIV_W'(`RX_FILT_DIV - 1));

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else if (tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// ----------------------------------------
	// output moves only when all taps agree
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			samples    <= '1;
			line_clean <= 1'b1;
		end else if (tick) begin
			samples <= {samples[`RX_FILT_TAPS-2:0], sync_q[1]};
			if (&samples) begin
				line_clean <= 1'b1;
			end else if (~|samples) begin
				line_clean <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/rx_char_if.sv
// received character bus
`timescale 1ns/100ps
`default_nettype none

interface rx_char_if;

	// one cycle strobe, fields below valid with it
	logic       char_vld;
	logic [7:0] char_data;
	// second stop period sampled low
	logic       char_sync;
	// first stop period sampled low
	logic       char_ferr;

	// ----------------------------------------
	modport framer (
		output char_vld,
		output char_data,
		output char_sync,
		output char_ferr
	);

	// no ready, a character is taken in any cycle
	modport assembler (
		input char_vld,
		input char_data,
		input char_sync,
		input char_ferr
	);

endinterface

`default_nettype wire

//--- rtl/sync_serial_rx_pkg.sv
// serial receiver types
`default_nettype none

package sync_serial_rx_pkg;

	// header opcode, upper nibble of the sync byte
	typedef enum logic [3:0] {
		OP_WRITE = 4'd1,
		OP_READ  = 4'd2,
		OP_EVENT = 4'd3,
		OP_NOP   = 4'd4
	} rx_op_t;

	// end of packet status
	typedef enum logic [1:0] {
		ST_OK,
		ST_BAD_SUM,
		ST_BAD_OP,
		ST_ABORT
	} rx_status_t;

	typedef enum logic [3:0] {
		IDLE, START, D7, D6, D5, D4, D3, D2, D1, D0, STOP1, STOP2, DONE
	} frm_state_t;

	typedef enum logic [1:0] {HUNT, PAYLOAD, CHECK} asm_state_t;

endpackage

`default_nettype wire

//--- include/sync_serial_rx_cfg.svh
// serial receiver configuration

`ifndef SYNC_SERIAL_RX_CFG_SVH
`define SYNC_SERIAL_RX_CFG_SVH

// width of the bit period input, in clk_sys cycles
`define RX_PERIOD_W 20

// clk_sys cycles between two filter samples
`define RX_FILT_DIV 2

// equal samples needed before the filtered line moves
`define RX_FILT_TAPS 4

// framer sample point needs a few ticks of margin,
// so tbit_period must be at least 8 * RX_FILT_DIV
`define RX_MIN_PERIOD (8 * `RX_FILT_DIV)

`endif
